// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_rx_xlate
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Fails unless the pass message shows up in the simulation output
sim: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+sim
source/rx_xlate_pkg.sv
source/rx_hdr_decode.sv
source/rx_hdr_parity_check.sv
source/rx_req_build.sv
source/rx_cpl_build.sv
source/rx_data_route.sv
source/rx_xlate_top.sv
sim/tb_clk_gen.sv
sim/tb_rx_xlate.sv

// ==== sim/tb_clk_gen.sv ====
// Clock and reset source for the RX translator testbench
// Reset is held low for the first cycles and again whenever rst_req is high
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  input  logic rst_req,   // Extra reset, driven by the test sequence
  output logic clk,
  output logic rst_b
);

  logic init_done;   // Power-on reset finished

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  initial begin
    init_done = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 init_done = 1'b1;   // Release just after an edge
  end

  assign rst_b = init_done & ~rst_req;

endmodule

`default_nettype wire

// ==== sim/tb_rx_ref.svh ====
// Reference model functions for the RX translator testbench
// Included inside the testbench module, which supplies DATA_DW and the package
`ifndef TB_RX_REF_SVH
`define TB_RX_REF_SVH

// Destination for a header from its flow class and channel
function automatic route_t route_for(fc_t fc, vc_t vc);
  if (fc == fc_posted && vc == 2'd0) return route_p;
  if (fc == fc_nonposted && vc == 2'd0) return route_np;
  if (fc == fc_completion && vc != 2'd0) return route_cpl;
  return route_none;
endfunction

function automatic cmd_kind_t kind_for(logic [7:0] ttype);
  case (ttype)
    8'h40, 8'h60: return kind_wr;
    8'h00, 8'h20: return kind_mem_rd;
    8'h04:        return kind_cfg_rd;
    8'h44:        return kind_cfg_wr;
    8'h0A, 8'h4A: return kind_cpl;
    8'h0B:        return kind_cpl_lk;
    default:      return kind_other;
  endcase
endfunction

// Request class, fused-off parts only issue user defined commands
function automatic req_cmd_t cmd_for(cmd_kind_t kind, logic fuse, logic has_data);
  if (kind == kind_wr || kind == kind_cfg_wr) begin
    if (fuse) return req_usr_d;
    return (kind == kind_wr) ? req_wr : req_cfg_wr;
  end
  if (kind == kind_mem_rd || kind == kind_cfg_rd) begin
    if (fuse) return req_usr_nd;
    return (kind == kind_mem_rd) ? req_mem_rd : req_cfg_rd;
  end
  return has_data ? req_usr_d : req_usr_nd;
endfunction

function automatic be_t first_be_for(hdr_t h);
  return h[45] ? h[49:46] : 4'hF;
endfunction

function automatic be_t last_be_for(hdr_t h);
  if (h[45]) return h[53:50];
  return (h[17:8] == 10'd1) ? 4'h0 : 4'hF;   // Single dword has no last BE
endfunction

function automatic cpl_status_t status_for(cmd_kind_t kind, cpl_status_t raw);
  if (kind == kind_cpl_lk) return 3'd7;
  case (raw)
    3'd3, 3'd5, 3'd6, 3'd7: return 3'd1;   // Reserved
    default:                return raw;
  endcase
endfunction

function automatic cpl_tag_t folded_tag(tag_t tag);
  return {(tag[9:8] != 2'b00), tag[7:0]};
endfunction

// Each dword's parity is its pair bit XOR the parity of its partner dword
function automatic logic [DATA_DW-1:0] dword_par(logic v, logic [DATA_DW*32-1:0] d,
                                                  logic [DATA_DW/2-1:0] pair_par);
  logic [DATA_DW-1:0] res;
  res = '0;
  if (v) begin
    for (int j = 0; j < DATA_DW; j++) begin
      res[j] = pair_par[j/2] ^ (^d[(j ^ 1)*32 +: 32]);
    end
  end
  return res;
endfunction

// Parity bit that makes the header and its info bits even
function automatic logic good_hdr_par(hdr_t h, vc_t vc, fc_t fc, logic has_data);
  return ^{h, vc, fc, has_data};
endfunction

`endif

// ==== sim/tb_rx_xlate.sv ====
// Testbench for the RX flit to non-flit translator
// Drives headers and data beats after each rising edge and checks all outputs
// against the reference model at the falling edge
`default_nettype none

module tb_rx_xlate
  import rx_xlate_pkg::*;
();

  localparam int DATA_DW      = 8;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 5;
  localparam int G_REQ  = 0;   // Error count groups
  localparam int G_CPL  = 1;
  localparam int G_DATA = 2;
  localparam int G_PAR  = 3;

  // Cycle budget of each test section for the watchdog
  localparam int N_POSTED = 16;
  localparam int N_NP     = 22;
  localparam int N_CPL    = 24;
  localparam int N_DATA   = 24;
  localparam int N_PAR    = 24;
  localparam int TEST_CYCLES = RESET_CYCLES + N_POSTED + N_NP + N_CPL + N_DATA + N_PAR + 4;
  localparam int WATCHDOG_MARGIN = 100;

  `include "tb_rx_ref.svh"

  logic prim_nonflr_clk, prim_gated_rst_b, rst_req;
  logic par_off, fuse_disable;
  logic hdr_v, hdr_has_data, hdr_par, data_v;
  vc_t  hdr_vc, data_vc;
  fc_t  hdr_fc, data_fc;
  hdr_t hdr;
  logic [DATA_DW*32-1:0] data, pkt_data;
  logic [DATA_DW/2-1:0]  data_par;
  logic [DATA_DW-1:0]    pkt_par;
  logic phdr_val, nphdr_val, req_poison, req_cmdlen_par;
  logic pdata_push, npdata_push, cpl_hdr_push, cpl_wdata, cpl_data_push, hdr_err;
  logic [1:0] req_addr_par;
  req_cmd_t req_cmd;
  addr_t    req_addr;
  len_t     req_len, cpl_len;
  tag_t     req_tag;
  rid_t     req_rid, cpl_cid;
  be_t      req_startbe, req_endbe;
  cpl_status_t cpl_status;
  cpl_tag_t    cpl_tag;
  bc_t         cpl_bc;

  logic [31:0] rng_state = 32'd90;
  logic        exp_stop;            // Model of the sticky stop state
  int          errs [4] = '{0, 0, 0, 0};
  int          checks   = 0;
  int          err_seen = 0;        // hdr_err cycles seen on the DUT

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
    .rst_req (rst_req),
    .clk     (prim_nonflr_clk),
    .rst_b   (prim_gated_rst_b)
  );

  rx_xlate_top #(.DATA_DW(DATA_DW)) i_dut (
    .prim_nonflr_clk, .prim_gated_rst_b, .par_off, .fuse_disable,
    .hdr_v, .hdr_vc, .hdr_fc, .hdr_has_data, .hdr_par, .hdr,
    .data_v, .data_vc, .data_fc, .data, .data_par,
    .phdr_val, .nphdr_val, .req_cmd, .req_addr, .req_len, .req_tag, .req_rid,
    .req_poison, .req_startbe, .req_endbe, .req_cmdlen_par, .req_addr_par,
    .pdata_push, .npdata_push, .pkt_data, .pkt_par,
    .cpl_hdr_push, .cpl_status, .cpl_tag, .cpl_cid, .cpl_bc, .cpl_len, .cpl_wdata,
    .cpl_data_push, .hdr_err
  );

  // ------------------------------------------------------------------------
  // Stimulus helpers

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic fc_t pick_fc(logic [31:0] r);
    case (r % 3)
      0:       return fc_posted;
      1:       return fc_nonposted;
      default: return fc_completion;
    endcase
  endfunction

  // Move to the next cycle and drop both valids
  task automatic next_cycle();
    @(posedge prim_nonflr_clk);
    #1;
    hdr_v  = 1'b0;
    data_v = 1'b0;
  endtask

  task automatic set_header(input fc_t fc, input vc_t vc, input logic [7:0] ttype,
                            input logic has_data, input logic one_dw, input logic bad);
    hdr_t h;
    h = {next_rand(), next_rand(), next_rand(), next_rand()};   // OHC bit random too
    h[HDR_TYPE_MSB:HDR_TYPE_LSB] = ttype;
    if (one_dw) h[HDR_LEN_MSB:HDR_LEN_LSB] = 10'd1;
    hdr          = h;
    hdr_vc       = vc;
    hdr_fc       = fc;
    hdr_has_data = has_data;
    hdr_par      = good_hdr_par(h, vc, fc, has_data) ^ bad;
    hdr_v        = 1'b1;
  endtask

  task automatic push_beat(input fc_t fc, input vc_t vc);
    logic [31:0] r;
    for (int i = 0; i < DATA_DW; i++) data[i*32 +: 32] = next_rand();
    r        = next_rand();
    data_par = r[DATA_DW/2-1:0];
    data_fc  = fc;
    data_vc  = vc;
    data_v   = 1'b1;
  endtask

  // ------------------------------------------------------------------------
  // Comparison

  task automatic check_val(input int grp, input string name,
                           input logic [255:0] got, input logic [255:0] expv);
    checks++;
    assert (got === expv) else begin
      errs[grp]++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, expv, $time);
    end
  endtask

  task automatic compare_outputs();
    route_t    r;
    cmd_kind_t k;
    req_cmd_t  e_cmd;
    addr_t     e_addr;
    logic      bad, e_err, e_acc;
    r     = route_for(hdr_fc, hdr_vc);
    k     = kind_for(hdr[7:0]);
    bad   = !par_off && (hdr_par != good_hdr_par(hdr, hdr_vc, hdr_fc, hdr_has_data));
    e_err = hdr_v && bad && !exp_stop;
    e_acc = hdr_v && !e_err && !exp_stop;
    if (hdr_err) err_seen++;
    check_val(G_PAR, "hdr_err", 256'(hdr_err), 256'(e_err));
    check_val(G_REQ, "phdr_val", 256'(phdr_val), 256'(e_acc && r == route_p));
    check_val(G_REQ, "nphdr_val", 256'(nphdr_val), 256'(e_acc && r == route_np));
    check_val(G_CPL, "cpl_hdr_push", 256'(cpl_hdr_push), 256'(e_acc && r == route_cpl));
    if (e_acc && (r == route_p || r == route_np)) begin
      e_cmd  = cmd_for(k, fuse_disable, hdr_has_data);
      e_addr = {hdr[127:66], 2'b00};
      check_val(G_REQ, "req_cmd", 256'(req_cmd), 256'(e_cmd));
      check_val(G_REQ, "req_addr", 256'(req_addr), 256'(e_addr));
      check_val(G_REQ, "req_len", 256'(req_len), 256'(hdr[17:8]));
      check_val(G_REQ, "req_tag", 256'(req_tag), 256'(hdr[27:18]));
      check_val(G_REQ, "req_rid", 256'(req_rid), 256'(hdr[43:28]));
      check_val(G_REQ, "req_poison", 256'(req_poison), 256'(hdr[44]));
      check_val(G_REQ, "req_startbe", 256'(req_startbe), 256'(first_be_for(hdr)));
      check_val(G_REQ, "req_endbe", 256'(req_endbe), 256'(last_be_for(hdr)));
      check_val(G_REQ, "req_cmdlen_par", 256'(req_cmdlen_par), 256'(^{e_cmd, hdr[17:8]}));
      check_val(G_REQ, "req_addr_par", 256'(req_addr_par),
                256'({^e_addr[63:32], ^e_addr[31:0]}));
    end
    if (e_acc && r == route_cpl) begin
      check_val(G_CPL, "cpl_status", 256'(cpl_status), 256'(status_for(k, hdr[56:54])));
      check_val(G_CPL, "cpl_tag", 256'(cpl_tag), 256'(folded_tag(hdr[27:18])));
      check_val(G_CPL, "cpl_cid", 256'(cpl_cid), 256'(hdr[127:112]));
      check_val(G_CPL, "cpl_bc", 256'(cpl_bc), 256'(hdr[75:64]));
      check_val(G_CPL, "cpl_len", 256'(cpl_len), 256'(hdr[17:8]));
      check_val(G_CPL, "cpl_wdata", 256'(cpl_wdata), 256'(hdr[6]));
    end
    // Data path is never blocked by the stop state
    check_val(G_DATA, "pdata_push", 256'(pdata_push),
              256'(data_v && data_vc == 2'd0 && data_fc == fc_posted));
    check_val(G_DATA, "npdata_push", 256'(npdata_push),
              256'(data_v && data_vc == 2'd0 && data_fc == fc_nonposted));
    check_val(G_DATA, "cpl_data_push", 256'(cpl_data_push),
              256'(data_v && data_vc != 2'd0 && data_fc == fc_completion));
    check_val(G_DATA, "pkt_data", 256'(pkt_data), data_v ? 256'(data) : 256'(0));
    check_val(G_DATA, "pkt_par", 256'(pkt_par), 256'(dword_par(data_v, data, data_par)));
    exp_stop = exp_stop | e_err;
  endtask

  always @(negedge prim_nonflr_clk) begin
    if (!prim_gated_rst_b) begin
      exp_stop = 1'b0;
    end else begin
      compare_outputs();
    end
  end

  // ------------------------------------------------------------------------
  // Test sections

  task automatic run_posted();
    logic [31:0] r;
    for (int f = 0; f < 2; f++) begin
      for (int i = 0; i < N_POSTED/2; i++) begin
        next_cycle();
        fuse_disable = (f == 1);
        r = next_rand();
        set_header(fc_posted, 2'd0, r[0] ? CMD_MWR64 : CMD_MWR32, 1'b1, (i % 3) == 0, 1'b0);
        hdr[HDR_OHC] = (i % 2) == 1;   // Alternate default and OHC byte enables
        hdr_par      = good_hdr_par(hdr, hdr_vc, hdr_fc, hdr_has_data);
        push_beat(fc_posted, 2'd0);
      end
    end
  endtask

  task automatic run_nonposted();
    logic [7:0]  codes [8] = '{CMD_MRD32, CMD_MRD64, CMD_CFGRD0, CMD_CFGWR0,
                               8'h01, 8'h30, 8'h74, 8'hFE};   // Last four unknown
    logic [31:0] r;
    for (int f = 0; f < 2; f++) begin
      for (int i = 0; i < 8; i++) begin
        next_cycle();
        fuse_disable = (f == 1);
        r = next_rand();
        set_header(fc_nonposted, 2'd0, codes[i], r[0], r[1], 1'b0);
      end
    end
    fuse_disable = 1'b0;
    for (int i = 0; i < 6; i++) begin   // Requests off channel 0 are dropped
      next_cycle();
      r = next_rand();
      set_header((i % 2) ? fc_nonposted : fc_posted, vc_t'(r % 3 + 1),
                 (i % 2) ? CMD_MRD32 : CMD_MWR32, r[4], 1'b0, 1'b0);
    end
  endtask

  task automatic run_completions();
    logic [7:0]  codes [4] = '{CMD_CPL, CMD_CPLD, CMD_CPLLK, 8'h4B};
    logic [31:0] r;
    vc_t         vc;
    for (int i = 0; i < N_CPL; i++) begin
      next_cycle();
      r  = next_rand();
      vc = ((i % 6) == 5) ? 2'd0 : vc_t'(r % 3 + 1);   // ch0 completion is dropped
      set_header(fc_completion, vc, codes[i % 4], (i % 4) == 1, 1'b0, 1'b0);
      if ((i % 4) == 1) push_beat(fc_completion, vc);
    end
  endtask

  task automatic run_data();
    for (int rep = 0; rep < 2; rep++) begin
      for (int f = 0; f < 3; f++) begin
        for (int v = 0; v < 4; v++) begin
          next_cycle();
          push_beat(pick_fc(32'(f)), vc_t'(v));
        end
      end
    end
  endtask

  task automatic run_parity();
    logic [31:0] r;
    next_cycle();
    par_off = 1'b1;   // Bad parity ignored
    set_header(fc_posted, 2'd0, CMD_MWR32, 1'b1, 1'b0, 1'b1);
    next_cycle();
    par_off = 1'b0;
    set_header(fc_nonposted, 2'd0, CMD_MRD32, 1'b0, 1'b0, 1'b1);
    for (int i = 0; i < 8; i++) begin   // Stop state drops the good headers
      next_cycle();
      r = next_rand();
      set_header((i % 2) ? fc_nonposted : fc_posted, 2'd0, CMD_MWR64, 1'b1, 1'b0, 1'b0);
      push_beat(pick_fc(32'(i)), (i % 3 == 2) ? vc_t'(r % 3 + 1) : 2'd0);   // Still pushes
    end
    next_cycle();
    rst_req = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    rst_req = 1'b0;
    for (int i = 0; i < 6; i++) begin
      next_cycle();
      set_header((i % 2) ? fc_nonposted : fc_posted, 2'd0, CMD_MRD64, 1'b0, 1'b0, 1'b0);
    end
    assert (err_seen == 1) else begin
      errs[G_PAR]++;
      $display("Header parity error fired %0d times instead of exactly once", err_seen);
    end
  endtask

  // ------------------------------------------------------------------------
  // Main sequence and watchdog

  initial begin
    rst_req      = 1'b0;
    par_off      = 1'b0;
    fuse_disable = 1'b0;
    hdr_v        = 1'b0;
    hdr_vc       = 2'd0;
    hdr_fc       = fc_posted;
    hdr_has_data = 1'b0;
    hdr_par      = 1'b0;
    hdr          = '0;
    data_v       = 1'b0;
    data_vc      = 2'd0;
    data_fc      = fc_posted;
    data         = '0;
    data_par     = '0;
    exp_stop     = 1'b0;
    wait (prim_gated_rst_b === 1'b1);
    run_posted();
    run_nonposted();
    run_completions();
    run_data();
    run_parity();
    next_cycle();
    @(negedge prim_nonflr_clk);   // Let the last idle cycle be compared
    $display("Checks %0d, errors req %0d cpl %0d data %0d parity %0d", checks,
             errs[G_REQ], errs[G_CPL], errs[G_DATA], errs[G_PAR]);
    if (errs[G_REQ] + errs[G_CPL] + errs[G_DATA] + errs[G_PAR] == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD);
    $display("Watchdog expired, the test sequence did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/rx_cpl_build.sv ====
// Completion header builder
// Maps flit completion status onto the supported set and folds the tag to 9 bits
`default_nettype none

module rx_cpl_build
  import rx_xlate_pkg::*;
(
  input  hdr_t        hdr,
  input  route_t      route,
  input  cmd_kind_t   kind,
  input  logic        hdr_accept,
  output logic        cpl_hdr_push,
  output cpl_status_t cpl_status,
  output cpl_tag_t    cpl_tag,
  output rid_t        cpl_cid,
  output bc_t         cpl_bc,
  output len_t        cpl_len,
  output logic        cpl_wdata    // Completion carries data
);

  cpl_status_t raw_status;
  tag_t        tag;

  assign raw_status = hdr[HDR_STATUS_MSB:HDR_STATUS_LSB];
  assign tag        = hdr[HDR_TAG_MSB:HDR_TAG_LSB];

  assign cpl_hdr_push = hdr_accept & (route == route_cpl);

  always_comb begin
    if (kind == kind_cpl_lk) begin
      cpl_status = cpl_status_t'(7);   // Locked completions not supported
    end else if ((raw_status == cpl_status_t'(3)) || (raw_status >= cpl_status_t'(5))) begin
      cpl_status = cpl_status_t'(1);   // Reserved codes become UR
    end else begin
      cpl_status = raw_status;
    end
  end

  // Only tags below 256 are issued, so any upper bit marks an unknown tag
  assign cpl_tag   = {tag[9] | tag[8], tag[7:0]};

  assign cpl_cid   = hdr[HDR_CID_MSB:HDR_CID_LSB];
  assign cpl_bc    = hdr[HDR_BC_MSB:HDR_BC_LSB];
  assign cpl_len   = hdr[HDR_LEN_MSB:HDR_LEN_LSB];
  assign cpl_wdata = hdr[HDR_TYPE_LSB + 6];   // Type bit 6 set for CplD

endmodule

`default_nettype wire

// ==== source/rx_data_route.sv ====
// Data beat router with parity regrouping
// Fabric parity is one bit per dword pair, the request side wants one per dword
`default_nettype none

module rx_data_route
  import rx_xlate_pkg::*;
#(
  parameter int DATA_DW = 8   // Dwords per beat, even
) (
  input  logic                    data_v,
  input  vc_t                     data_vc,
  input  fc_t                     data_fc,
  input  logic [DATA_DW*32-1:0]   data,
  input  logic [DATA_DW/2-1:0]    data_par,
  output logic                    pdata_push,
  output logic                    npdata_push,
  output logic                    cpl_data_push,
  output logic [DATA_DW*32-1:0]   pkt_data,
  output logic [DATA_DW-1:0]      pkt_par
);

  // P and NP data on ch0 only, completion data on the others
  assign pdata_push    = data_v & (data_vc == '0) & (data_fc == fc_posted);
  assign npdata_push   = data_v & (data_vc == '0) & (data_fc == fc_nonposted);
  assign cpl_data_push = data_v & (data_vc != '0) & (data_fc == fc_completion);

  assign pkt_data = data_v ? data : '0;   // Zero when idle

  // Pair parity XOR the partner dword gives the parity of each single dword
  always_comb begin
    pkt_par = '0;
    if (data_v) begin
      for (int i = 0; i < DATA_DW/2; i++) begin
        pkt_par[2*i]   = data_par[i] ^ (^data[(2*i+1)*32 +: 32]);  // Upper dword
        pkt_par[2*i+1] = data_par[i] ^ (^data[(2*i)*32 +: 32]);    // Lower dword
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rx_hdr_decode.sv ====
// Header classifier for the RX translator
// Picks the output route from flow class and channel, sorts the flit type into a
// command kind and works out the default or OHC supplied byte enables
`default_nettype none

module rx_hdr_decode
  import rx_xlate_pkg::*;
(
  input  logic      hdr_v,
  input  vc_t       hdr_vc,
  input  fc_t       hdr_fc,
  input  hdr_t      hdr,
  output route_t    route,
  output cmd_kind_t kind,
  output be_t       startbe,
  output be_t       endbe
);

  logic [7:0] ttype;   // Flit type field
  len_t       len;
  logic       ohc;

  assign ttype = hdr[HDR_TYPE_MSB:HDR_TYPE_LSB];
  assign len   = hdr[HDR_LEN_MSB:HDR_LEN_LSB];
  assign ohc   = hdr[HDR_OHC];

  // P and NP only expected on ch0, completions only on the other channels
  always_comb begin
    route = route_none;
    if (hdr_v) begin
      if ((hdr_fc == fc_posted) && (hdr_vc == '0)) route = route_p;
      else if ((hdr_fc == fc_nonposted) && (hdr_vc == '0)) route = route_np;
      else if ((hdr_fc == fc_completion) && (hdr_vc != '0)) route = route_cpl;
    end
  end

  always_comb begin
    case (ttype)
      CMD_MWR32, CMD_MWR64: kind = kind_wr;
      CMD_MRD32, CMD_MRD64: kind = kind_mem_rd;
      CMD_CFGRD0:           kind = kind_cfg_rd;
      CMD_CFGWR0:           kind = kind_cfg_wr;
      CMD_CPL, CMD_CPLD:    kind = kind_cpl;
      CMD_CPLLK:            kind = kind_cpl_lk;
      default:              kind = kind_other;   // Everything else is user defined
    endcase
  end

  // Flit mode default is all ones, last BE zero for a single dword
  always_comb begin
    startbe = '1;
    endbe   = (len == len_t'(1)) ? '0 : '1;
    if (ohc) begin   // OHC overrides both
      startbe = hdr[HDR_FBE_MSB:HDR_FBE_LSB];
      endbe   = hdr[HDR_LBE_MSB:HDR_LBE_LSB];
    end
  end

endmodule

`default_nettype wire

// ==== source/rx_hdr_parity_check.sv ====
// Header parity check with a sticky stop state
// After the first bad header every later header is dropped until reset
`default_nettype none

module rx_hdr_parity_check
  import rx_xlate_pkg::*;
(
  input  logic prim_nonflr_clk,
  input  logic prim_gated_rst_b,
  input  logic par_off,        // Parity checking disabled
  input  logic hdr_v,
  input  logic hdr_par,
  input  hdr_t hdr,
  input  vc_t  hdr_vc,
  input  fc_t  hdr_fc,
  input  logic hdr_has_data,
  output logic hdr_err,
  output logic hdr_accept
);

  logic par_bad;   // Odd parity over header and info bits
  logic hdr_stop;  // Sticky until reset

  // Fabric parity covers the info bits as well as the header itself
  assign par_bad    = ~par_off & (^{hdr_par, hdr, hdr_vc, hdr_fc, hdr_has_data});

  assign hdr_err    = hdr_v & par_bad & ~hdr_stop;   // Fires once only
  assign hdr_accept = hdr_v & ~hdr_err & ~hdr_stop;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      hdr_stop <= 1'b0;
    end else begin
      hdr_stop <= hdr_stop | hdr_err;
    end
  end

endmodule

`default_nettype wire

// ==== source/rx_req_build.sv ====
// Request builder for the posted and non-posted outputs
// Both share one set of field ports since only one class is valid per cycle
// Command class follows the flit kind, with the fuse disable override
`default_nettype none

module rx_req_build
  import rx_xlate_pkg::*;
(
  input  hdr_t      hdr,
  input  logic      has_data,
  input  logic      fuse_disable,   // Device fused off, no real requests
  input  route_t    route,
  input  cmd_kind_t kind,
  input  be_t       startbe,
  input  be_t       endbe,
  input  logic      hdr_accept,
  output logic      phdr_val,
  output logic      nphdr_val,
  output req_cmd_t  req_cmd,
  output addr_t     req_addr,
  output len_t      req_len,
  output tag_t      req_tag,
  output rid_t      req_rid,
  output logic      req_poison,
  output be_t       req_startbe,
  output be_t       req_endbe,
  output logic      req_cmdlen_par,
  output logic [1:0] req_addr_par
);

  //--------------------------------------------------------------------------
  // Push strobes

  assign phdr_val  = hdr_accept & (route == route_p);
  assign nphdr_val = hdr_accept & (route == route_np);

  //--------------------------------------------------------------------------
  // Command translation

  always_comb begin
    case (kind)
      kind_wr:     req_cmd = fuse_disable ? req_usr_d  : req_wr;
      kind_mem_rd: req_cmd = fuse_disable ? req_usr_nd : req_mem_rd;
      kind_cfg_wr: req_cmd = fuse_disable ? req_usr_d  : req_cfg_wr;
      kind_cfg_rd: req_cmd = fuse_disable ? req_usr_nd : req_cfg_rd;
      default: begin
        // Unsupported, class only follows the data flag
        req_cmd = has_data ? req_usr_d : req_usr_nd;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // Header fields

  // Config requests use the same plain address field
  assign req_addr    = {hdr[HDR_DWADDR_MSB:HDR_DWADDR_LSB], 2'b00};
  assign req_len     = hdr[HDR_LEN_MSB:HDR_LEN_LSB];
  assign req_tag     = hdr[HDR_TAG_MSB:HDR_TAG_LSB];
  assign req_rid     = hdr[HDR_RID_MSB:HDR_RID_LSB];
  assign req_poison  = hdr[HDR_POISON];
  assign req_startbe = startbe;   // Defaulted or OHC value from decode
  assign req_endbe   = endbe;

  //--------------------------------------------------------------------------
  // Parity towards the request queue

  assign req_cmdlen_par = ^{req_cmd, req_len};

  // One bit per address half
  assign req_addr_par = {^req_addr[63:32],
                         ^req_addr[31:0]};

endmodule

`default_nettype wire

// ==== source/rx_xlate_pkg.sv ====
// Shared types, header field offsets and flit command codes for the RX translator
// Imported with a wildcard by each RTL block and by the testbench
`default_nettype none

package rx_xlate_pkg;

  //--------------------------------------------------------------------------
  // Plain vector types

  typedef logic [127:0] hdr_t;        // Flit mode transaction header
  typedef logic [1:0]   vc_t;         // Fabric channel
  typedef logic [63:0]  addr_t;       // Byte address
  typedef logic [9:0]   len_t;        // Length in dwords
  typedef logic [9:0]   tag_t;        // Full request tag
  typedef logic [15:0]  rid_t;        // Requester or completer ID
  typedef logic [3:0]   be_t;         // Byte enables
  typedef logic [2:0]   cpl_status_t; // Completion status
  typedef logic [8:0]   cpl_tag_t;    // Folded completion tag
  typedef logic [11:0]  bc_t;         // Byte count

  //--------------------------------------------------------------------------
  // Enumerations

  typedef enum logic [1:0] {
    fc_posted     = 2'd0,
    fc_nonposted  = 2'd1,
    fc_completion = 2'd2
  } fc_t;

  // Header destination after classification
  typedef enum logic [1:0] {
    route_p    = 2'd0,
    route_np   = 2'd1,
    route_cpl  = 2'd2,
    route_none = 2'd3
  } route_t;

  typedef enum logic [2:0] {
    kind_wr     = 3'd0,
    kind_mem_rd = 3'd1,
    kind_cfg_rd = 3'd2,
    kind_cfg_wr = 3'd3,
    kind_cpl    = 3'd4,
    kind_cpl_lk = 3'd5,
    kind_other  = 3'd6
  } cmd_kind_t;

  // Non-flit request command class
  typedef enum logic [2:0] {
    req_wr     = 3'd0,
    req_mem_rd = 3'd1,
    req_cfg_wr = 3'd2,
    req_cfg_rd = 3'd3,
    req_usr_d  = 3'd4,   // User defined, with data
    req_usr_nd = 3'd5    // User defined, no data
  } req_cmd_t;

  //--------------------------------------------------------------------------
  // Header field offsets

  localparam int HDR_TYPE_LSB    = 0;
  localparam int HDR_TYPE_MSB    = 7;
  localparam int HDR_LEN_LSB     = 8;
  localparam int HDR_LEN_MSB     = 17;
  localparam int HDR_TAG_LSB     = 18;
  localparam int HDR_TAG_MSB     = 27;
  localparam int HDR_RID_LSB     = 28;
  localparam int HDR_RID_MSB     = 43;
  localparam int HDR_POISON      = 44;
  localparam int HDR_OHC         = 45;   // Optional header content present
  localparam int HDR_FBE_LSB     = 46;
  localparam int HDR_FBE_MSB     = 49;
  localparam int HDR_LBE_LSB     = 50;
  localparam int HDR_LBE_MSB     = 53;
  localparam int HDR_STATUS_LSB  = 54;
  localparam int HDR_STATUS_MSB  = 56;
  localparam int HDR_DWADDR_LSB  = 66;   // Address bits 63:2
  localparam int HDR_DWADDR_MSB  = 127;
  localparam int HDR_BC_LSB      = 64;   // Completion only
  localparam int HDR_BC_MSB      = 75;
  localparam int HDR_CID_LSB     = 112;  // Completion only
  localparam int HDR_CID_MSB     = 127;

  //--------------------------------------------------------------------------
  // Flit command codes

  localparam logic [7:0] CMD_MWR32  = 8'h40;
  localparam logic [7:0] CMD_MWR64  = 8'h60;
  localparam logic [7:0] CMD_MRD32  = 8'h00;
  localparam logic [7:0] CMD_MRD64  = 8'h20;
  localparam logic [7:0] CMD_CFGRD0 = 8'h04;
  localparam logic [7:0] CMD_CFGWR0 = 8'h44;
  localparam logic [7:0] CMD_CPL    = 8'h0A;
  localparam logic [7:0] CMD_CPLD   = 8'h4A;
  localparam logic [7:0] CMD_CPLLK  = 8'h0B;

endpackage

`default_nettype wire

// ==== source/rx_xlate_top.sv ====
// Top level of the RX flit to non-flit translator
// Connects header decode, parity check, request and completion builders and the
// data router; all translation paths are combinational
`default_nettype none

module rx_xlate_top
  import rx_xlate_pkg::*;
#(
  parameter int DATA_DW = 8   // Dwords per data beat
) (
  input  logic                  prim_nonflr_clk,
  input  logic                  prim_gated_rst_b,

  //--------------------------------------------------------------------------
  // Configuration
  input  logic                  par_off,
  input  logic                  fuse_disable,

  //--------------------------------------------------------------------------
  // Fabric header and data pushes
  input  logic                  hdr_v,
  input  vc_t                   hdr_vc,
  input  fc_t                   hdr_fc,
  input  logic                  hdr_has_data,
  input  logic                  hdr_par,
  input  hdr_t                  hdr,
  input  logic                  data_v,
  input  vc_t                   data_vc,
  input  fc_t                   data_fc,
  input  logic [DATA_DW*32-1:0] data,
  input  logic [DATA_DW/2-1:0]  data_par,   // One bit per two dwords

  //--------------------------------------------------------------------------
  // Request side
  output logic                  phdr_val,
  output logic                  nphdr_val,
  output req_cmd_t              req_cmd,
  output addr_t                 req_addr,
  output len_t                  req_len,
  output tag_t                  req_tag,
  output rid_t                  req_rid,
  output logic                  req_poison,
  output be_t                   req_startbe,
  output be_t                   req_endbe,
  output logic                  req_cmdlen_par,
  output logic [1:0]            req_addr_par,
  output logic                  pdata_push,
  output logic                  npdata_push,
  output logic [DATA_DW*32-1:0] pkt_data,
  output logic [DATA_DW-1:0]    pkt_par,    // One bit per dword

  //--------------------------------------------------------------------------
  // Inbound completions and errors
  output logic                  cpl_hdr_push,
  output cpl_status_t           cpl_status,
  output cpl_tag_t              cpl_tag,
  output rid_t                  cpl_cid,
  output bc_t                   cpl_bc,
  output len_t                  cpl_len,
  output logic                  cpl_wdata,
  output logic                  cpl_data_push,
  output logic                  hdr_err
);

  route_t    route;
  cmd_kind_t kind;
  be_t       startbe;
  be_t       endbe;
  logic      hdr_accept;   // Header passed parity and not stopped

  rx_hdr_decode i_decode (
    .hdr_v   (hdr_v),
    .hdr_vc  (hdr_vc),
    .hdr_fc  (hdr_fc),
    .hdr     (hdr),
    .route   (route),
    .kind    (kind),
    .startbe (startbe),
    .endbe   (endbe)
  );

  rx_hdr_parity_check i_parity (
    .prim_nonflr_clk  (prim_nonflr_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .par_off          (par_off),
    .hdr_v            (hdr_v),
    .hdr_par          (hdr_par),
    .hdr              (hdr),
    .hdr_vc           (hdr_vc),
    .hdr_fc           (hdr_fc),
    .hdr_has_data     (hdr_has_data),
    .hdr_err          (hdr_err),
    .hdr_accept       (hdr_accept)
  );

  rx_req_build i_req (
    .hdr            (hdr),
    .has_data       (hdr_has_data),
    .fuse_disable   (fuse_disable),
    .route          (route),
    .kind           (kind),
    .startbe        (startbe),
    .endbe          (endbe),
    .hdr_accept     (hdr_accept),
    .phdr_val       (phdr_val),
    .nphdr_val      (nphdr_val),
    .req_cmd        (req_cmd),
    .req_addr       (req_addr),
    .req_len        (req_len),
    .req_tag        (req_tag),
    .req_rid        (req_rid),
    .req_poison     (req_poison),
    .req_startbe    (req_startbe),
    .req_endbe      (req_endbe),
    .req_cmdlen_par (req_cmdlen_par),
    .req_addr_par   (req_addr_par)
  );

  rx_cpl_build i_cpl (
    .hdr          (hdr),
    .route        (route),
    .kind         (kind),
    .hdr_accept   (hdr_accept),
    .cpl_hdr_push (cpl_hdr_push),
    .cpl_status   (cpl_status),
    .cpl_tag      (cpl_tag),
    .cpl_cid      (cpl_cid),
    .cpl_bc       (cpl_bc),
    .cpl_len      (cpl_len),
    .cpl_wdata    (cpl_wdata)
  );

  // Data path ignores the header stop state
  rx_data_route #(
    .DATA_DW (DATA_DW)
  ) i_data (
    .data_v        (data_v),
    .data_vc       (data_vc),
    .data_fc       (data_fc),
    .data          (data),
    .data_par      (data_par),
    .pdata_push    (pdata_push),
    .npdata_push   (npdata_push),
    .cpl_data_push (cpl_data_push),
    .pkt_data      (pkt_data),
    .pkt_par       (pkt_par)
  );

endmodule

`default_nettype wire
